// ==== hw/mm_pkg.sv ====
/* Shared dimensions, widths, element and beat types, sequencer states
   and the packed row-write and output-beat structs */
package mm_pkg;

    // Matrix geometry
    localparam int ELEM_WIDTH    = 16;                      // Q8.8 element
    localparam int FRAC_WIDTH    = 8;                       // Fraction bits
    localparam int CHUNK_SIZE    = 4;                       // Elements per beat
    localparam int INNER_DIM     = 4;                       // Shared dimension
    localparam int I_ROWS        = 8;                       // Rows of I
    localparam int W_ROWS        = 6;                       // Rows of W
    localparam int NUM_RESULTS   = I_ROWS * W_ROWS;         // 48 results
    localparam int NUM_OUT_BEATS = NUM_RESULTS / CHUNK_SIZE; // 12 beats
    localparam int WORD_WIDTH    = CHUNK_SIZE * ELEM_WIDTH; // 64-bit beat

    // Buffer sizes
    localparam int I_FIFO_DEPTH  = 16;                      // Two I problems
    localparam int W_FIFO_DEPTH  = 8;                       // One W problem plus slack
    localparam int O_FIFO_DEPTH  = 16;                      // One full result set

    typedef logic signed [ELEM_WIDTH-1:0]     elem_t;       // Signed Q8.8
    typedef logic [WORD_WIDTH-1:0]            word_t;       // One stream beat
    typedef logic [$clog2(I_ROWS)-1:0]        i_addr_t;     // I row index
    typedef logic [$clog2(W_ROWS)-1:0]        w_addr_t;     // W row index
    typedef logic [$clog2(NUM_OUT_BEATS)-1:0] beat_cnt_t;   // Output beat index

    typedef enum logic [1:0]
    {
        SEQ_IDLE,   // Wait for both operand sets
        SEQ_LOAD,   // Pop rows into core stores
        SEQ_START,  // One-cycle start
        SEQ_RUN     // Wait for core done
    } seq_state_t;

    typedef struct packed
    {
        logic    en;    // Write strobe
        i_addr_t addr;  // Target row
        word_t   data;  // Row payload
    } i_row_wr_t;

    typedef struct packed
    {
        logic    en;
        w_addr_t addr;
        word_t   data;
    } w_row_wr_t;

    typedef struct packed
    {
        logic  last;    // Final beat of a result set
        word_t data;    // Four packed results
    } out_beat_t;

endpackage

// ==== hw/stream_fifo.sv ====
/* First-word-fall-through FIFO with valid/ready on both sides
   and an occupancy count */
`timescale 1ns/1ps

module stream_fifo #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 64
) (
    input  logic                       aclk,
    input  logic                       aresetn,
    // Write side
    input  logic [WIDTH-1:0]           in_data_i,
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    // Read side, head word always presented
    output logic [WIDTH-1:0]           out_data_o,
    output logic                       out_valid_o,
    input  logic                       out_ready_i,
    output logic [$clog2(DEPTH+1)-1:0] count_o
);

    logic [WIDTH-1:0]         mem [DEPTH];  // Storage, no reset
    logic [$clog2(DEPTH)-1:0] wr_ptr;       // Next free slot
    logic [$clog2(DEPTH)-1:0] rd_ptr;       // Head slot
    logic                     push;
    logic                     pop;

    assign in_ready_o  = (count_o < DEPTH);     // Not full
    assign out_valid_o = (count_o != '0);      // Not empty
    assign out_data_o  = mem[rd_ptr];          // No read latency
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge aclk)
    begin
        if (push)
            mem[wr_ptr] <= in_data_i;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1; // Wrap at end
            if (pop)
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count_o <= count_o + 1'b1;  // Write only
                2'b01:   count_o <= count_o - 1'b1;  // Read only
                default: count_o <= count_o;         // Both or neither
            endcase
        end
    end

    // Occupancy bounded by storage and in step with the pointers
    a_count_bound : assert property (@(posedge aclk) disable iff (!aresetn)
        count_o <= DEPTH &&
        ((wr_ptr == rd_ptr) == (count_o == '0 || count_o == DEPTH)));

    // Stalled head holds its word
    a_head_stable : assert property (@(posedge aclk) disable iff (!aresetn)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

// ==== hw/load_sequencer.sv ====
/* Control FSM that waits for full operand sets in both input FIFOs,
   streams the rows into the core stores and starts the core */
`timescale 1ns/1ps

module load_sequencer (
    input  logic                                     aclk,
    input  logic                                     aresetn,
    // FIFO occupancy and head rows
    input  logic [$clog2(mm_pkg::I_FIFO_DEPTH+1)-1:0] i_count_i,
    input  logic [$clog2(mm_pkg::W_FIFO_DEPTH+1)-1:0] w_count_i,
    input  mm_pkg::word_t                            i_head_i,
    input  mm_pkg::word_t                            w_head_i,
    output logic                                     i_pop_o,
    output logic                                     w_pop_o,
    // Core store writes
    output mm_pkg::i_row_wr_t                        i_wr_o,
    output mm_pkg::w_row_wr_t                        w_wr_o,
    // Core handshake
    output logic                                     start_o,
    input  logic                                     done_i
);
    import mm_pkg::*;

    seq_state_t state;
    i_addr_t    row_cnt;         // Load cycle, also I row
    w_addr_t    w_idx;           // W row, saturates
    logic       operands_ready;

    // Both FIFOs hold one complete problem
    assign operands_ready = (i_count_i >= I_ROWS) && (w_count_i >= W_ROWS);

    // I pops on every load cycle, W only on the first W_ROWS
    assign i_pop_o = (state == SEQ_LOAD);
    assign w_pop_o = (state == SEQ_LOAD) && (row_cnt < W_ROWS);
    assign start_o = (state == SEQ_START);

    always_comb
    begin
        i_wr_o.en   = i_pop_o;      // Write the row being popped
        i_wr_o.addr = row_cnt;
        i_wr_o.data = i_head_i;
        w_wr_o.en   = w_pop_o;
        w_wr_o.addr = w_idx;
        w_wr_o.data = w_head_i;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state   <= SEQ_IDLE;
            row_cnt <= '0;
            w_idx   <= '0;
        end
        else
        begin
            case (state)
                SEQ_IDLE:
                begin
                    if (operands_ready)
                        state <= SEQ_LOAD;
                end
                SEQ_LOAD:
                begin
                    row_cnt <= row_cnt + 1'b1;
                    if (w_idx != w_addr_t'(W_ROWS - 1))
                        w_idx <= w_idx + 1'b1;          // Hold on last W row
                    if (row_cnt == i_addr_t'(I_ROWS - 1))
                    begin
                        row_cnt <= '0;                  // Ready for next problem
                        w_idx   <= '0;
                        state   <= SEQ_START;
                    end
                end
                SEQ_START:
                begin
                    state <= SEQ_RUN;                   // Single start cycle
                end
                SEQ_RUN:
                begin
                    if (done_i)
                        state <= SEQ_IDLE;
                end
                default:
                begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Pops never from an empty FIFO
    a_pop_legal : assert property (@(posedge aclk) disable iff (!aresetn)
        (i_pop_o -> i_count_i != '0) && (w_pop_o -> w_count_i != '0));

    // Core completion only after a start
    a_done_in_run : assert property (@(posedge aclk) disable iff (!aresetn)
        done_i |-> state == SEQ_RUN);

endmodule

// ==== hw/matmul_core.sv ====
/* Operand stores, four signed Q8.8 dot-product lanes and output beat
   emission for C = I x W transposed, four results per beat */
`timescale 1ns/1ps

module matmul_core (
    input  logic              aclk,
    input  logic              aresetn,
    // Operand row writes from the sequencer
    input  mm_pkg::i_row_wr_t i_wr_i,
    input  mm_pkg::w_row_wr_t w_wr_i,
    // Run control
    input  logic              start_i,
    output logic              done_o,
    // Result beats toward the output FIFO
    output mm_pkg::out_beat_t beat_o,
    output logic              beat_valid_o,
    input  logic              beat_ready_i
);
    import mm_pkg::*;

    word_t     i_mem [I_ROWS];    // Input rows
    word_t     w_mem [W_ROWS];    // Weight rows
    beat_cnt_t beat_cnt;          // Beat currently offered
    beat_cnt_t beat_nxt;          // Beat to load next
    logic      beat_acc;          // Beat taken by FIFO
    logic      load_beat;         // Register a new beat
    word_t     packed_res;        // Four results of beat_nxt
    int        res_idx [CHUNK_SIZE]; // Row-major result index per lane

    // Signed dot product of two rows, scaled back to Q8.8
    function automatic elem_t dot_q88(word_t a_row, word_t b_row);
        logic signed [2*ELEM_WIDTH+1:0] sum;   // Four full products plus growth
        elem_t                          a_el;
        elem_t                          b_el;
        sum = '0;
        for (int j = 0; j < INNER_DIM; j++)
        begin
            a_el = elem_t'(a_row[j*ELEM_WIDTH +: ELEM_WIDTH]);  // Element 0 in low bits
            b_el = elem_t'(b_row[j*ELEM_WIDTH +: ELEM_WIDTH]);
            sum  = sum + a_el * b_el;
        end
        return elem_t'(sum >>> FRAC_WIDTH);     // Truncate, no rounding
    endfunction

    always_ff @(posedge aclk)
    begin
        if (i_wr_i.en)
            i_mem[i_wr_i.addr] <= i_wr_i.data;
        if (w_wr_i.en)
            w_mem[w_wr_i.addr] <= w_wr_i.data;
    end

    assign beat_acc  = beat_valid_o && beat_ready_i;
    assign load_beat = start_i || (beat_acc && !beat_o.last);  // Advance until last taken
    assign beat_nxt  = start_i ? '0 : beat_cnt + 1'b1;

    // Result r uses I row r / W_ROWS and W row r % W_ROWS
    always_comb
    begin
        packed_res = '0;
        for (int l = 0; l < CHUNK_SIZE; l++)
        begin
            res_idx[l] = int'(beat_nxt) * CHUNK_SIZE + l;
            packed_res[l*ELEM_WIDTH +: ELEM_WIDTH] =
                dot_q88(i_mem[res_idx[l] / W_ROWS], w_mem[res_idx[l] % W_ROWS]);
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            beat_valid_o <= 1'b0;
            beat_cnt     <= '0;
            done_o       <= 1'b0;
        end
        else
        begin
            done_o <= beat_acc && beat_o.last;  // Pulse after final beat leaves
            if (load_beat)
            begin
                beat_valid_o <= 1'b1;
                beat_cnt     <= beat_nxt;
            end
            else if (beat_acc)
            begin
                beat_valid_o <= 1'b0;           // Result set drained
            end
        end
    end

    // Beat payload, held while the FIFO stalls
    always_ff @(posedge aclk)
    begin
        if (load_beat)
        begin
            beat_o.data <= packed_res;
            beat_o.last <= (beat_nxt == beat_cnt_t'(NUM_OUT_BEATS - 1));
        end
    end

    // A new run never overlaps beats still waiting
    a_start_idle : assert property (@(posedge aclk) disable iff (!aresetn)
        start_i |-> !beat_valid_o && !done_o);

    // Offered beat stays put until accepted
    a_beat_hold : assert property (@(posedge aclk) disable iff (!aresetn)
        beat_valid_o && !beat_ready_i |=> beat_valid_o && $stable(beat_o));

endmodule

// ==== hw/mm_stream_top.sv ====
/* Top level: operand FIFOs, load sequencer, matmul core and output FIFO
   behind AXI-Stream slave and master ports */
`timescale 1ns/1ps

module mm_stream_top (
    input  logic          aclk,
    input  logic          aresetn,
    // I operand slave stream
    input  mm_pkg::word_t s_axis_i_tdata_i,
    input  logic          s_axis_i_tvalid_i,
    output logic          s_axis_i_tready_o,
    // W operand slave stream
    input  mm_pkg::word_t s_axis_w_tdata_i,
    input  logic          s_axis_w_tvalid_i,
    output logic          s_axis_w_tready_o,
    // Result master stream
    output mm_pkg::word_t m_axis_tdata_o,
    output logic          m_axis_tvalid_o,
    output logic          m_axis_tlast_o,
    input  logic          m_axis_tready_i
);
    import mm_pkg::*;

    logic [$clog2(I_FIFO_DEPTH+1)-1:0] i_count;   // Buffered I rows
    logic [$clog2(W_FIFO_DEPTH+1)-1:0] w_count;   // Buffered W rows
    word_t                             i_head;
    word_t                             w_head;
    logic                              i_pop;
    logic                              w_pop;
    i_row_wr_t                         i_wr;
    w_row_wr_t                         w_wr;
    logic                              core_start;
    logic                              core_done;
    out_beat_t                         core_beat;     // Core to o_fifo
    logic                              core_valid;
    logic                              core_ready;
    out_beat_t                         o_head;        // tlast rides with data

    stream_fifo #(.DEPTH(I_FIFO_DEPTH), .WIDTH(WORD_WIDTH)) i_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .in_data_i(s_axis_i_tdata_i), .in_valid_i(s_axis_i_tvalid_i),
        .in_ready_o(s_axis_i_tready_o),
        .out_data_o(i_head), .out_valid_o(), .out_ready_i(i_pop),
        .count_o(i_count)
    );

    stream_fifo #(.DEPTH(W_FIFO_DEPTH), .WIDTH(WORD_WIDTH)) w_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .in_data_i(s_axis_w_tdata_i), .in_valid_i(s_axis_w_tvalid_i),
        .in_ready_o(s_axis_w_tready_o),
        .out_data_o(w_head), .out_valid_o(), .out_ready_i(w_pop),
        .count_o(w_count)
    );

    load_sequencer u_seq (
        .aclk(aclk), .aresetn(aresetn),
        .i_count_i(i_count), .w_count_i(w_count),
        .i_head_i(i_head), .w_head_i(w_head),
        .i_pop_o(i_pop), .w_pop_o(w_pop),
        .i_wr_o(i_wr), .w_wr_o(w_wr),
        .start_o(core_start), .done_i(core_done)
    );

    matmul_core u_core (
        .aclk(aclk), .aresetn(aresetn),
        .i_wr_i(i_wr), .w_wr_i(w_wr),
        .start_i(core_start), .done_o(core_done),
        .beat_o(core_beat), .beat_valid_o(core_valid), .beat_ready_i(core_ready)
    );

    stream_fifo #(.DEPTH(O_FIFO_DEPTH), .WIDTH($bits(out_beat_t))) o_fifo (
        .aclk(aclk), .aresetn(aresetn),
        .in_data_i(core_beat), .in_valid_i(core_valid), .in_ready_o(core_ready),
        .out_data_o(o_head), .out_valid_o(m_axis_tvalid_o),
        .out_ready_i(m_axis_tready_i),
        .count_o()
    );

    assign m_axis_tdata_o = o_head.data;
    assign m_axis_tlast_o = o_head.last;

endmodule

// ==== bench/tb_mm_stream_top.sv ====
/* Testbench for mm_stream_top: clock, reset, operand streams, reference model,
   concurrent output checks, watchdog and summary */
`timescale 1ns/1ps

module tb_mm_stream_top;
    import mm_pkg::*;

    localparam int NUM_PROBLEMS   = 5;                       // Plain, gapped, three back to back
    localparam int PROBLEM_CYCLES = 400;                     // Generous per problem at 50 % stall
    localparam int TIMEOUT_CYCLES = NUM_PROBLEMS * PROBLEM_CYCLES + 1000; // Plus reset and idle

    logic  aclk = 1'b0;
    logic  aresetn;
    word_t s_axis_i_tdata_i;
    logic  s_axis_i_tvalid_i;
    logic  s_axis_i_tready_o;
    word_t s_axis_w_tdata_i;
    logic  s_axis_w_tvalid_i;
    logic  s_axis_w_tready_o;
    word_t m_axis_tdata_o;
    logic  m_axis_tvalid_o;
    logic  m_axis_tlast_o;
    logic  m_axis_tready_i;

    int    seed;                  // Operand data and gaps
    int    ready_seed;            // Output back-pressure
    logic  rand_ready;            // Random tready enable
    logic  started;               // First operand driven
    word_t i_rows [I_ROWS];       // Current problem I
    word_t w_rows [W_ROWS];       // Current problem W
    word_t exp_q [$];             // Expected beats in order
    int    exp_total;             // Beats queued so far
    word_t exp_head;              // Next expected beat
    logic  exp_last;              // Next beat ends a set
    int    out_cnt;               // Accepted output beats
    int    out_prob;              // Problem of next beat
    int    i_acc;                 // Accepted I beats
    int    w_acc;                 // Accepted W beats
    int    cycle_cnt;
    int    mismatch_cnt;
    int    other_cnt;

    always #20 aclk = ~aclk;      // 40 ns period

    mm_stream_top dut (
        .aclk(aclk), .aresetn(aresetn),
        .s_axis_i_tdata_i(s_axis_i_tdata_i), .s_axis_i_tvalid_i(s_axis_i_tvalid_i),
        .s_axis_i_tready_o(s_axis_i_tready_o),
        .s_axis_w_tdata_i(s_axis_w_tdata_i), .s_axis_w_tvalid_i(s_axis_w_tvalid_i),
        .s_axis_w_tready_o(s_axis_w_tready_o),
        .m_axis_tdata_o(m_axis_tdata_o), .m_axis_tvalid_o(m_axis_tvalid_o),
        .m_axis_tlast_o(m_axis_tlast_o), .m_axis_tready_i(m_axis_tready_i)
    );

    assign out_prob = out_cnt / NUM_OUT_BEATS;
    assign exp_last = (out_cnt % NUM_OUT_BEATS) == (NUM_OUT_BEATS - 1);

    // Expected C = I x W transposed, row-major, element 0 in low bits
    task automatic build_expected();
        longint sum;
        elem_t  a_el;
        elem_t  b_el;
        word_t  beat;
        int     r;
        for (int k = 0; k < NUM_OUT_BEATS; k++)
        begin
            beat = '0;
            for (int l = 0; l < CHUNK_SIZE; l++)
            begin
                r   = k * CHUNK_SIZE + l;
                sum = 0;
                for (int j = 0; j < INNER_DIM; j++)
                begin
                    a_el = i_rows[r / W_ROWS][j*ELEM_WIDTH +: ELEM_WIDTH];
                    b_el = w_rows[r % W_ROWS][j*ELEM_WIDTH +: ELEM_WIDTH];
                    sum  = sum + longint'(a_el) * longint'(b_el);   // Full signed product
                end
                beat[l*ELEM_WIDTH +: ELEM_WIDTH] = elem_t'(sum >>> FRAC_WIDTH); // Q8.8, truncated
            end
            exp_q.push_back(beat);
            exp_total = exp_total + 1;
        end
        exp_head = exp_q[0];
    endtask

    // One row per accepted beat, optional idle gaps after each
    task automatic send_i_rows(input int max_gap);
        int gap;
        for (int r = 0; r < I_ROWS; r++)
        begin
            s_axis_i_tdata_i  = i_rows[r];
            s_axis_i_tvalid_i = 1'b1;
            while (!s_axis_i_tready_o)
                @(negedge aclk);                 // Ready only moves on rising edges
            @(negedge aclk);                     // Taken on the edge just passed
            s_axis_i_tvalid_i = 1'b0;
            gap = (max_gap > 0) ? {$random(seed)} % (max_gap + 1) : 0;
            repeat (gap) @(negedge aclk);
        end
    endtask

    task automatic send_w_rows();
        for (int r = 0; r < W_ROWS; r++)
        begin
            s_axis_w_tdata_i  = w_rows[r];
            s_axis_w_tvalid_i = 1'b1;
            while (!s_axis_w_tready_o)
                @(negedge aclk);
            @(negedge aclk);
            s_axis_w_tvalid_i = 1'b0;
        end
    endtask

    // Mode 0 streams both in parallel, mode 1 sends W first then gapped I
    task automatic run_problem(input int mode);
        for (int r = 0; r < I_ROWS; r++)
            i_rows[r] = {$random(seed), $random(seed)};
        for (int r = 0; r < W_ROWS; r++)
            w_rows[r] = {$random(seed), $random(seed)};
        build_expected();
        if (mode == 1)
        begin
            send_w_rows();
            send_i_rows(3);
        end
        else
        begin
            fork
                send_i_rows(0);
                send_w_rows();
            join
        end
    endtask

    always @(negedge aclk)
        m_axis_tready_i = rand_ready ? ($random(ready_seed) & 1) != 0 : 1'b1;

    // Scoreboard bookkeeping on every transfer
    always @(posedge aclk)
    begin
        if (aresetn)
        begin
            if (s_axis_i_tvalid_i && s_axis_i_tready_o)
                i_acc <= i_acc + 1;
            if (s_axis_w_tvalid_i && s_axis_w_tready_o)
                w_acc <= w_acc + 1;
            if (m_axis_tvalid_o && m_axis_tready_i)
            begin
                if (exp_q.size() != 0)
                    void'(exp_q.pop_front());
                exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
                out_cnt  <= out_cnt + 1;
            end
        end
    end

    always @(posedge aclk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, %0d of %0d output beats received",
                     cycle_cnt, out_cnt, NUM_PROBLEMS * NUM_OUT_BEATS);
            $display("Verification failed");
            $finish;
        end
    end

    // Quiet outputs and open inputs before any operand
    a_idle : assert property (@(posedge aclk) disable iff (!aresetn)
        !started |-> !m_axis_tvalid_o && s_axis_i_tready_o && s_axis_w_tready_o)
        else
        begin
            other_cnt++;
            $display("Output valid or input ready wrong before any problem was started");
        end

    a_beat_expected : assert property (@(posedge aclk) disable iff (!aresetn)
        m_axis_tvalid_o && m_axis_tready_i |-> out_cnt < exp_total)
        else
        begin
            other_cnt++;
            $display("Output beat accepted with no result expected");
        end

    a_data : assert property (@(posedge aclk) disable iff (!aresetn)
        m_axis_tvalid_o && m_axis_tready_i |-> m_axis_tdata_o == exp_head)
        else
        begin
            mismatch_cnt++;
            $display("MISMATCH m_axis_tdata_o beat %0d: got %h expected %h",
                     $sampled(out_cnt), $sampled(m_axis_tdata_o), $sampled(exp_head));
        end

    a_last : assert property (@(posedge aclk) disable iff (!aresetn)
        m_axis_tvalid_o && m_axis_tready_i |-> m_axis_tlast_o == exp_last)
        else
        begin
            mismatch_cnt++;
            $display("MISMATCH m_axis_tlast_o beat %0d: got %h expected %h",
                     $sampled(out_cnt), $sampled(m_axis_tlast_o), $sampled(exp_last));
        end

    // Stalled beat stays offered and unchanged
    a_hold : assert property (@(posedge aclk) disable iff (!aresetn)
        m_axis_tvalid_o && !m_axis_tready_i |=>
            m_axis_tvalid_o && $stable(m_axis_tdata_o) && $stable(m_axis_tlast_o))
        else
        begin
            other_cnt++;
            $display("Output beat dropped or changed while the master port was stalled");
        end

    a_no_early : assert property (@(posedge aclk) disable iff (!aresetn)
        m_axis_tvalid_o |->
            i_acc >= I_ROWS * (out_prob + 1) && w_acc >= W_ROWS * (out_prob + 1))
        else
        begin
            other_cnt++;
            $display("Output of problem %0d appeared before its operands were all accepted",
                     $sampled(out_prob));
        end

    initial
    begin
        seed              = 32'hf7fc_02df;
        ready_seed        = seed ^ 32'h5a5a_5a5a;
        aresetn           = 1'b0;
        s_axis_i_tdata_i  = '0;
        s_axis_i_tvalid_i = 1'b0;
        s_axis_w_tdata_i  = '0;
        s_axis_w_tvalid_i = 1'b0;
        m_axis_tready_i   = 1'b1;
        rand_ready        = 1'b0;
        started           = 1'b0;
        exp_head          = '0;
        exp_total         = 0;
        out_cnt           = 0;
        i_acc             = 0;
        w_acc             = 0;
        cycle_cnt         = 0;
        mismatch_cnt      = 0;
        other_cnt         = 0;
        repeat (16) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        repeat (10) @(negedge aclk);       // Idle window after reset
        started = 1'b1;
        run_problem(0);                    // Free-flowing output
        rand_ready = 1'b1;
        run_problem(1);                    // W first, I with gaps, stalls
        for (int p = 0; p < 3; p++)
            run_problem(0);                // Back to back under stalls
        wait (out_cnt == NUM_PROBLEMS * NUM_OUT_BEATS);
        repeat (5) @(negedge aclk);
        if (exp_q.size() != 0)
        begin
            other_cnt++;
            $display("%0d expected beats were never received", exp_q.size());
        end
        $display("Summary: %0d beats checked, %0d mismatches, %0d other errors",
                 out_cnt, mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== sim.f ====
hw/mm_pkg.sv
hw/stream_fifo.sv
hw/load_sequencer.sv
hw/matmul_core.sv
hw/mm_stream_top.sv
bench/tb_mm_stream_top.sv

// ==== Makefile ====
# Verilator build for the streaming matrix multiplier

TOOL     = verilator
FLAGS    = --timing --assert -Wno-fatal
TOP      = tb_mm_stream_top
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
